/* logic/seed_queue_pkg.sv */
package seed_queue_pkg;

	// ==============================
	// sizes
	// ==============================
	localparam int READ_NUM_W  = 8;   // read number bits
	localparam int MAX_READS   = 256; // reads in flight
	localparam int IV_KEEP_W   = 33;  // kept bits of a bi-interval word
	localparam int INFO_KEEP_W = 14;  // info bits 38:32 and 6:0

	// context states, anything else is illegal
	typedef enum logic [5:0] {
		F_INIT  = 6'h00, // fresh read, no query yet
		F_RUN   = 6'h01, // extension running
		F_BREAK = 6'h02, // leaves without a response
		BUBBLE  = 6'h30  // empty slot
	} ctx_status_t;

	typedef logic [6:0]   pos_t;      // position, index or pointer
	typedef logic [7:0]   base_t;     // nucleobase code from read RAM
	typedef logic [63:0]  iv_word_t;  // bi-interval word as on ports
	typedef logic [63:0]  iv_info_t;  // interval info as on ports
	typedef logic [767:0] occ_resp_t; // occ counts from DRAM

	// ==============================
	// ring entry layout, msb first
	// ptr_curr, read_num, x0, x1, x2, info hi, info lo,
	// forward_i, min_intv, backward_x, base, status
	// ==============================
	localparam int CTX_PAYLOAD_W = 4 * $bits(pos_t) + READ_NUM_W
		+ 3 * IV_KEEP_W + INFO_KEEP_W;
	localparam int CTX_ENTRY_W = CTX_PAYLOAD_W + $bits(base_t)
		+ $bits(ctx_status_t);

	typedef logic [CTX_PAYLOAD_W-1:0] ctx_payload_t; // entry minus base and status
	typedef logic [CTX_ENTRY_W-1:0]   ctx_entry_t;

endpackage

/* logic/query_delay_line.sv */
`timescale 1ns/100ps

module query_delay_line import seed_queue_pkg::*; #(
	parameter int READ_NUM_W = seed_queue_pkg::READ_NUM_W
) (
	input  logic                  Clk_32UI,
	input  logic                  reset_n,
	input  logic                  stall,
	// incoming forward context
	input  ctx_status_t           status,
	input  pos_t                  ptr_curr,
	input  logic [READ_NUM_W-1:0] read_num,
	input  iv_word_t              ik_x0,
	input  iv_word_t              ik_x1,
	input  iv_word_t              ik_x2,
	input  iv_info_t              ik_info,
	input  pos_t                  forward_i,
	input  pos_t                  min_intv,
	input  pos_t                  backward_x,
	input  pos_t                  next_query_position,
	// read RAM
	output pos_t                  query_position,
	output logic [READ_NUM_W-1:0] query_read_num,
	output logic [5:0]            query_status,
	input  base_t                 query_base,
	// to ring
	output ctx_entry_t            wr_entry,
	output logic                  wr_valid
);

	localparam int STAGES = 3; // read RAM latency

	logic         send_query;
	ctx_payload_t payload_in;
	ctx_status_t  status_l  [STAGES];
	ctx_payload_t payload_l [STAGES];

	// ==============================
	// query request to read RAM
	// ==============================
	assign send_query = (status != BUBBLE) && (status != F_BREAK); // break needs no base

	assign query_position = send_query ? next_query_position : '1;
	assign query_read_num = send_query ? read_num : '1;
	assign query_status   = send_query ? status : '1;

	// truncate once, stages carry only kept bits
	assign payload_in = {ptr_curr, read_num,
		ik_x0[IV_KEEP_W-1:0], ik_x1[IV_KEEP_W-1:0], ik_x2[IV_KEEP_W-1:0],
		ik_info[38:32], ik_info[6:0],
		forward_i, min_intv, backward_x};

	// ==============================
	// wait for the base
	// ==============================
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			for (int i = 0; i < STAGES; i++)
				status_l[i] <= BUBBLE;
			wr_valid <= 1'b0;
		end else if (!stall) begin
			status_l[0] <= status;
			for (int i = 1; i < STAGES; i++)
				status_l[i] <= status_l[i-1];
			wr_valid <= (status_l[STAGES-1] != BUBBLE); // bubbles ride along, no write
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			payload_l[0] <= payload_in;
			for (int i = 1; i < STAGES; i++)
				payload_l[i] <= payload_l[i-1];
			// base arrives with the last stage
			wr_entry <= {payload_l[STAGES-1], query_base, status_l[STAGES-1]};
		end
	end

endmodule

/* logic/context_ring.sv */
`timescale 1ns/100ps

module context_ring import seed_queue_pkg::*; #(
	parameter int DEPTH = 2 * MAX_READS
) (
	input  logic       Clk_32UI,
	input  logic       reset_n,
	input  logic       stall,
	input  ctx_entry_t wr_entry,
	input  logic       wr_valid,
	input  logic       pop,
	output ctx_entry_t head_entry,
	output logic       not_empty,
	output logic       ring_overflow
);

	localparam int AW = $clog2(DEPTH);

	ctx_entry_t  mem [DEPTH];
	logic [AW:0] wr_ptr; // extra msb tells wrap
	logic [AW:0] rd_ptr;
	logic        full;
	logic        do_write;

	assign not_empty = (wr_ptr != rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) &&
		(wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign do_write = !stall && wr_valid && !full; // full ring drops the entry

	assign head_entry = mem[rd_ptr[AW-1:0]]; // async read of head

	// ==============================
	// pointers and overflow
	// ==============================
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			ring_overflow <= 1'b0;
		end else if (!stall) begin
			if (wr_valid && full)
				ring_overflow <= 1'b1; // sticky until reset
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && not_empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge Clk_32UI) begin
		if (do_write)
			mem[wr_ptr[AW-1:0]] <= wr_entry;
	end

endmodule

/* logic/response_fifo.sv */
`timescale 1ns/100ps

module response_fifo import seed_queue_pkg::*; #(
	parameter int DEPTH = MAX_READS
) (
	input  logic      Clk_32UI,
	input  logic      reset_n,
	input  logic      dram_get, // keeps writing through stall
	input  occ_resp_t occ_in,
	input  logic      pop,
	output occ_resp_t occ_head,
	output logic      resp_pending,
	output logic      resp_overflow
);

	localparam int AW = $clog2(DEPTH);

	occ_resp_t   mem [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [AW:0] count; // wraps cleanly with the extra bit
	logic        full;

	assign count        = wr_ptr - rd_ptr;
	assign full         = (count == DEPTH[AW:0]);
	assign resp_pending = (count != '0);
	assign occ_head     = mem[rd_ptr[AW-1:0]]; // oldest response

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			resp_overflow <= 1'b0;
		end else begin
			if (dram_get && full)
				resp_overflow <= 1'b1; // response lost, flag sticks
			else if (dram_get)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && resp_pending)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (dram_get && !full)
			mem[wr_ptr[AW-1:0]] <= occ_in;
	end

endmodule

/* logic/dispatch_ctrl.sv */
`timescale 1ns/100ps

module dispatch_ctrl import seed_queue_pkg::*; #(
	parameter int READ_NUM_W = seed_queue_pkg::READ_NUM_W
) (
	input  logic                  Clk_32UI,
	input  logic                  reset_n,
	input  logic                  stall,
	// ring and fifo heads
	input  ctx_entry_t            head_entry,
	input  logic                  not_empty,
	input  occ_resp_t             occ_head,
	input  logic                  resp_pending,
	// host side new read
	input  logic                  load_done,
	input  logic                  new_read_valid,
	input  logic [READ_NUM_W-1:0] new_read_num,
	input  iv_word_t              new_ik_x0,
	input  iv_word_t              new_ik_x1,
	input  iv_word_t              new_ik_x2,
	input  iv_info_t              new_ik_info,
	input  pos_t                  new_forward_i,
	input  pos_t                  new_min_intv,
	// pops, single cycle
	output logic                  ring_pop,
	output logic                  resp_pop,
	output logic                  new_read,
	// forward pipeline
	output ctx_status_t           status_out,
	output pos_t                  ptr_curr_out,
	output logic [READ_NUM_W-1:0] read_num_out,
	output iv_word_t              ik_x0_out,
	output iv_word_t              ik_x1_out,
	output iv_word_t              ik_x2_out,
	output iv_info_t              ik_info_out,
	output pos_t                  forward_i_out,
	output pos_t                  min_intv_out,
	output pos_t                  backward_x_out,
	output base_t                 query_out,
	output occ_resp_t             occ_out
);

	typedef enum logic [1:0] {
		SEL_BREAK,  // break, ring only
		SEL_PAIR,   // context plus oldest response
		SEL_INJECT, // fresh read from host
		SEL_BUBBLE
	} disp_sel_t;

	localparam int PAD_W = 64 - IV_KEEP_W;

	disp_sel_t             sel;
	pos_t                  h_ptr_curr;
	logic [READ_NUM_W-1:0] h_read_num;
	logic [IV_KEEP_W-1:0]  h_x0;
	logic [IV_KEEP_W-1:0]  h_x1;
	logic [IV_KEEP_W-1:0]  h_x2;
	logic [6:0]            h_info_hi; // info 38:32
	logic [6:0]            h_info_lo; // info 6:0
	pos_t                  h_forward_i;
	pos_t                  h_min_intv;
	pos_t                  h_backward_x;
	base_t                 h_base;
	logic [5:0]            h_status;

	assign {h_ptr_curr, h_read_num, h_x0, h_x1, h_x2, h_info_hi, h_info_lo,
		h_forward_i, h_min_intv, h_backward_x, h_base, h_status} = head_entry;

	// ==============================
	// per cycle decision
	// ==============================
	always_comb begin
		if (not_empty && h_status == F_BREAK)
			sel = SEL_BREAK;
		else if (not_empty && resp_pending)
			sel = SEL_PAIR;
		else if (resp_pending)
			sel = SEL_BUBBLE; // response waits for its context
		else if (load_done && new_read_valid)
			sel = SEL_INJECT;
		else
			sel = SEL_BUBBLE;
	end

	assign ring_pop = !stall && (sel == SEL_BREAK || sel == SEL_PAIR);
	assign resp_pop = !stall && (sel == SEL_PAIR);
	assign new_read = load_done && new_read_valid && !resp_pending && !stall;

	// ==============================
	// registered outputs
	// ==============================
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			status_out <= BUBBLE;
		end else if (!stall) begin
			unique case (sel)
				SEL_BREAK, SEL_PAIR: status_out <= ctx_status_t'(h_status);
				SEL_INJECT:          status_out <= F_INIT;
				default:             status_out <= BUBBLE;
			endcase
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			unique case (sel)
				SEL_BREAK, SEL_PAIR: begin
					ptr_curr_out   <= h_ptr_curr;
					read_num_out   <= h_read_num;
					ik_x0_out      <= {{PAD_W{1'b0}}, h_x0}; // zero extend
					ik_x1_out      <= {{PAD_W{1'b0}}, h_x1};
					ik_x2_out      <= {{PAD_W{1'b0}}, h_x2};
					ik_info_out    <= {25'd0, h_info_hi, 25'd0, h_info_lo};
					forward_i_out  <= h_forward_i;
					min_intv_out   <= h_min_intv;
					backward_x_out <= h_backward_x;
					query_out      <= h_base;
					if (sel == SEL_PAIR)
						occ_out <= occ_head; // counts for this context
				end
				SEL_INJECT: begin
					ptr_curr_out   <= '0;
					read_num_out   <= new_read_num;
					ik_x0_out      <= new_ik_x0;
					ik_x1_out      <= new_ik_x1;
					ik_x2_out      <= new_ik_x2;
					ik_info_out    <= new_ik_info;
					forward_i_out  <= new_forward_i + 7'd1;
					min_intv_out   <= new_min_intv;
					backward_x_out <= new_forward_i;
					query_out      <= '0; // first round has no query
				end
				default: begin
					ptr_curr_out   <= '1;
					read_num_out   <= '1;
					ik_x0_out      <= '1;
					ik_x1_out      <= '1;
					ik_x2_out      <= '1;
					ik_info_out    <= '1;
					forward_i_out  <= '1;
					min_intv_out   <= '1;
					backward_x_out <= '1;
					query_out      <= '1;
				end
			endcase
		end
	end

endmodule

/* logic/seed_queue_top.sv */
`timescale 1ns/100ps

module seed_queue_top import seed_queue_pkg::*; #(
	parameter int READ_NUM_W = seed_queue_pkg::READ_NUM_W,
	parameter int MAX_READS  = seed_queue_pkg::MAX_READS
) (
	input  logic                  Clk_32UI,
	input  logic                  reset_n,
	input  logic                  stall,
	// forward pipeline in
	input  ctx_status_t           status,
	input  pos_t                  ptr_curr,
	input  logic [READ_NUM_W-1:0] read_num,
	input  iv_word_t              ik_x0,
	input  iv_word_t              ik_x1,
	input  iv_word_t              ik_x2,
	input  iv_info_t              ik_info,
	input  pos_t                  forward_i,
	input  pos_t                  min_intv,
	input  pos_t                  backward_x,
	input  pos_t                  next_query_position,
	// read RAM
	output pos_t                  query_position,
	output logic [READ_NUM_W-1:0] query_read_num,
	output logic [5:0]            query_status,
	input  base_t                 query_base,
	// DRAM responses
	input  logic                  dram_get,
	input  occ_resp_t             occ_in,
	// forward pipeline out
	output ctx_status_t           status_out,
	output pos_t                  ptr_curr_out,
	output logic [READ_NUM_W-1:0] read_num_out,
	output iv_word_t              ik_x0_out,
	output iv_word_t              ik_x1_out,
	output iv_word_t              ik_x2_out,
	output iv_info_t              ik_info_out,
	output pos_t                  forward_i_out,
	output pos_t                  min_intv_out,
	output pos_t                  backward_x_out,
	output base_t                 query_out,
	output occ_resp_t             occ_out,
	// new reads from host
	output logic                  new_read,
	input  logic                  load_done,
	input  logic                  new_read_valid,
	input  logic [READ_NUM_W-1:0] new_read_num,
	input  iv_word_t              new_ik_x0,
	input  iv_word_t              new_ik_x1,
	input  iv_word_t              new_ik_x2,
	input  iv_info_t              new_ik_info,
	input  pos_t                  new_forward_i,
	input  pos_t                  new_min_intv,
	// sticky error flags
	output logic                  ring_overflow,
	output logic                  resp_overflow
);

	ctx_entry_t wr_entry;   // delay line to ring
	logic       wr_valid;
	ctx_entry_t head_entry; // ring head to dispatcher
	logic       not_empty;
	logic       ring_pop;
	occ_resp_t  occ_head;   // fifo head to dispatcher
	logic       resp_pending;
	logic       resp_pop;

	query_delay_line #(.READ_NUM_W(READ_NUM_W)) u_delay (
		.Clk_32UI, .reset_n, .stall,
		.status, .ptr_curr, .read_num, .ik_x0, .ik_x1, .ik_x2, .ik_info,
		.forward_i, .min_intv, .backward_x, .next_query_position,
		.query_position, .query_read_num, .query_status, .query_base,
		.wr_entry, .wr_valid
	);

	// twice the reads, a context may sit here while its twin waits
	context_ring #(.DEPTH(2 * MAX_READS)) u_ring (
		.Clk_32UI, .reset_n, .stall,
		.wr_entry, .wr_valid, .pop(ring_pop),
		.head_entry, .not_empty, .ring_overflow
	);

	response_fifo #(.DEPTH(MAX_READS)) u_resp (
		.Clk_32UI, .reset_n,
		.dram_get, .occ_in, .pop(resp_pop),
		.occ_head, .resp_pending, .resp_overflow
	);

	dispatch_ctrl #(.READ_NUM_W(READ_NUM_W)) u_disp (
		.Clk_32UI, .reset_n, .stall,
		.head_entry, .not_empty, .occ_head, .resp_pending,
		.load_done, .new_read_valid, .new_read_num,
		.new_ik_x0, .new_ik_x1, .new_ik_x2, .new_ik_info,
		.new_forward_i, .new_min_intv,
		.ring_pop, .resp_pop, .new_read,
		.status_out, .ptr_curr_out, .read_num_out,
		.ik_x0_out, .ik_x1_out, .ik_x2_out, .ik_info_out,
		.forward_i_out, .min_intv_out, .backward_x_out, .query_out, .occ_out
	);

endmodule

/* tests/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic Clk_32UI,
	output logic reset_n
);

	initial begin
		Clk_32UI = 1'b0;
		forever #(PERIOD_NS / 2) Clk_32UI = ~Clk_32UI;
	end

	// low from time zero, released on a rising edge
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clk_32UI);
		reset_n <= 1'b1;
	end

endmodule

/* tests/seed_queue_chk.sv */
`timescale 1ns/100ps

module seed_queue_chk import seed_queue_pkg::*; (
	input logic       Clk_32UI,
	input logic       reset_n,
	input logic       stall,
	input logic [5:0] status_out,
	input logic       new_read,
	input logic       ring_pop,
	input logic       not_empty
);

	int assert_fails = 0; // failures so far, summed into the run total

	// ==============================
	// dispatcher outputs
	// ==============================
	legal_status: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		status_out inside {F_INIT, F_RUN, F_BREAK, BUBBLE})
	else begin
		assert_fails++;
		$error("status_out holds illegal code %h", status_out);
	end

	// host read only taken while running
	no_read_in_stall: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		$rose(new_read) |-> !stall)
	else begin
		assert_fails++;
		$error("new_read rose during stall");
	end

	no_pop_when_empty: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		ring_pop |-> not_empty)
	else begin
		assert_fails++;
		$error("ring_pop high while ring is empty");
	end

endmodule

bind seed_queue_top seed_queue_chk u_chk (
	.Clk_32UI, .reset_n, .stall, .status_out, .new_read, .ring_pop, .not_empty
);

/* tests/seed_queue_tb.sv */
`timescale 1ns/100ps

module seed_queue_tb import seed_queue_pkg::*; ();

	localparam int RN_W      = READ_NUM_W;
	localparam int NUM_TESTS = 6;
	localparam int STIM_CYC  = MAX_READS + 300; // overflow test is the long one
	localparam int WDOG_CYC  = STIM_CYC + 200 * NUM_TESTS;

	typedef struct packed {
		logic [5:0]      status;
		pos_t            ptr_curr;
		logic [RN_W-1:0] read_num;
		iv_word_t        x0;
		iv_word_t        x1;
		iv_word_t        x2;
		iv_info_t        info;
		pos_t            forward_i;
		pos_t            min_intv;
		pos_t            backward_x;
		base_t           query;
		logic            paired; // takes the next response
	} exp_out_t;

	logic            Clk_32UI, reset_n, stall, dram_get, load_done, new_read_valid;
	logic            new_read, ring_overflow, resp_overflow;
	ctx_status_t     status, status_out;
	pos_t            ptr_curr, forward_i, min_intv, backward_x, next_query_position;
	pos_t            query_position, new_forward_i, new_min_intv;
	pos_t            ptr_curr_out, forward_i_out, min_intv_out, backward_x_out;
	logic [RN_W-1:0] read_num, query_read_num, read_num_out, new_read_num;
	logic [5:0]      query_status;
	iv_word_t        ik_x0, ik_x1, ik_x2, new_ik_x0, new_ik_x1, new_ik_x2;
	iv_word_t        ik_x0_out, ik_x1_out, ik_x2_out;
	iv_info_t        ik_info, new_ik_info, ik_info_out;
	base_t           query_base, query_out;
	occ_resp_t       occ_in, occ_out;

	integer    seed = 32'h9ec3_ad0d;
	int        errors = 0;
	int        cyc = 0;
	logic      out_fresh = 1'b0; // outputs were updated at the last edge
	string     test_name = "reset";
	base_t     base_sched [8];   // read RAM model, slot per cycle
	exp_out_t  exp_q [$];
	string     name_q [$];
	occ_resp_t occ_exp_q [$];

	clock_gen u_clk (.Clk_32UI, .reset_n);

	seed_queue_top #(.READ_NUM_W(RN_W), .MAX_READS(MAX_READS)) dut (
		.Clk_32UI, .reset_n, .stall,
		.status, .ptr_curr, .read_num, .ik_x0, .ik_x1, .ik_x2, .ik_info,
		.forward_i, .min_intv, .backward_x, .next_query_position,
		.query_position, .query_read_num, .query_status, .query_base,
		.dram_get, .occ_in,
		.status_out, .ptr_curr_out, .read_num_out, .ik_x0_out, .ik_x1_out, .ik_x2_out,
		.ik_info_out, .forward_i_out, .min_intv_out, .backward_x_out, .query_out, .occ_out,
		.new_read, .load_done, .new_read_valid, .new_read_num,
		.new_ik_x0, .new_ik_x1, .new_ik_x2, .new_ik_info, .new_forward_i, .new_min_intv,
		.ring_overflow, .resp_overflow
	);

	// ==============================
	// reference model
	// ==============================
	function automatic exp_out_t expect_entry(input logic [5:0] st, input pos_t ptr,
		input logic [RN_W-1:0] rn, input iv_word_t x0, input iv_word_t x1,
		input iv_word_t x2, input iv_info_t info, input pos_t fi, input pos_t mi,
		input pos_t bx, input base_t base, input logic from_ring);
		exp_out_t e;
		e.status     = st;
		e.ptr_curr   = ptr;
		e.read_num   = rn;
		e.forward_i  = fi;
		e.min_intv   = mi;
		e.backward_x = bx;
		e.query      = base;
		e.paired     = from_ring && (st != F_BREAK); // breaks skip the fifo
		if (from_ring) begin
			e.x0   = {31'd0, x0[32:0]}; // ring keeps 33 bits
			e.x1   = {31'd0, x1[32:0]};
			e.x2   = {31'd0, x2[32:0]};
			e.info = {25'd0, info[38:32], 25'd0, info[6:0]};
		end else begin
			e.x0   = x0;
			e.x1   = x1;
			e.x2   = x2;
			e.info = info;
		end
		return e;
	endfunction

	function automatic iv_word_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic check_val(input string tname, input string field,
		input logic [63:0] expv, input logic [63:0] actv);
		if (actv !== expv) begin
			errors++;
			$display("CHECK FAILED [%s] %s: expected %h, actual %h", tname, field, expv, actv);
		end
	endtask

	// ==============================
	// stimulus helpers
	// ==============================
	task automatic tick();
		@(negedge Clk_32UI);
		cyc++;
		query_base     = base_sched[cyc % 8];
		status         = BUBBLE;
		dram_get       = 1'b0;
		load_done      = 1'b0;
		new_read_valid = 1'b0;
	endtask

	task automatic present_context(input ctx_status_t st);
		base_t b;
		logic  send;
		status              = st;
		ptr_curr            = pos_t'($random(seed));
		read_num            = RN_W'($random(seed));
		ik_x0               = rand_word();
		ik_x1               = rand_word();
		ik_x2               = rand_word();
		ik_info             = rand_word();
		forward_i           = pos_t'($random(seed));
		min_intv            = pos_t'($random(seed));
		backward_x          = pos_t'($random(seed));
		next_query_position = pos_t'($random(seed));
		b                   = base_t'($random(seed));
		base_sched[(cyc + 3) % 8] = b; // RAM answers three cycles on
		send = (st != BUBBLE) && (st != F_BREAK);
		#1;
		check_val(test_name, "query_position", send ? next_query_position : 7'h7f,
			query_position);
		check_val(test_name, "query_read_num", send ? read_num : {RN_W{1'b1}},
			query_read_num);
		check_val(test_name, "query_status", send ? st : 6'h3f, query_status);
		if (st != BUBBLE) begin
			exp_q.push_back(expect_entry(st, ptr_curr, read_num, ik_x0, ik_x1, ik_x2,
				ik_info, forward_i, min_intv, backward_x, b, 1'b1));
			name_q.push_back(test_name);
		end
	endtask

	task automatic send_response(input logic track);
		dram_get = 1'b1;
		for (int i = 0; i < 24; i++)
			occ_in[i*32 +: 32] = $random(seed);
		if (track)
			occ_exp_q.push_back(occ_in);
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			tick();
		repeat (2) tick();
	endtask

	// ==============================
	// comparator
	// ==============================
	always @(posedge Clk_32UI)
		out_fresh <= reset_n && !stall;

	always @(negedge Clk_32UI) begin
		exp_out_t  e;
		occ_resp_t occ_e;
		string     nm;
		if (out_fresh && status_out != BUBBLE) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("ERROR: output with status %h appeared but none was expected",
					status_out);
			end else begin
				e  = exp_q.pop_front();
				nm = name_q.pop_front();
				check_val(nm, "status_out", e.status, status_out);
				check_val(nm, "ptr_curr_out", e.ptr_curr, ptr_curr_out);
				check_val(nm, "read_num_out", e.read_num, read_num_out);
				check_val(nm, "ik_x0_out", e.x0, ik_x0_out);
				check_val(nm, "ik_x1_out", e.x1, ik_x1_out);
				check_val(nm, "ik_x2_out", e.x2, ik_x2_out);
				check_val(nm, "ik_info_out", e.info, ik_info_out);
				check_val(nm, "forward_i_out", e.forward_i, forward_i_out);
				check_val(nm, "min_intv_out", e.min_intv, min_intv_out);
				check_val(nm, "backward_x_out", e.backward_x, backward_x_out);
				check_val(nm, "query_out", e.query, query_out);
				if (e.paired && occ_exp_q.size() == 0) begin
					errors++;
					$display("ERROR: [%s] context left paired but no response was sent", nm);
				end else if (e.paired) begin
					occ_e = occ_exp_q.pop_front();
					if (occ_out !== occ_e) begin
						errors++;
						$display("CHECK FAILED [%s] occ_out: expected %h, actual %h",
							nm, occ_e, occ_out);
					end
				end
			end
		end
	end

	initial begin
		repeat (WDOG_CYC) @(posedge Clk_32UI);
		$display("ERROR: watchdog expired after %0d cycles, %0d outputs still missing",
			WDOG_CYC, exp_q.size());
		$display("Verification failed");
		$finish;
	end

	// ==============================
	// tests
	// ==============================
	initial begin
		int              sent;
		int              need;
		int              assert_errs;
		ctx_status_t     st;
		ctx_status_t     hold_st;
		logic [RN_W-1:0] hold_rn;
		logic [63:0]     hold_occ;
		stall = 1'b0;
		status = BUBBLE;
		{ptr_curr, forward_i, min_intv, backward_x, next_query_position} = '0;
		{read_num, ik_x0, ik_x1, ik_x2, ik_info, query_base} = '0;
		{dram_get, occ_in, load_done, new_read_valid, new_read_num} = '0;
		{new_ik_x0, new_ik_x1, new_ik_x2, new_ik_info, new_forward_i, new_min_intv} = '0;
		for (int i = 0; i < 8; i++)
			base_sched[i] = '0;
		wait (reset_n === 1'b1);
		tick();
		check_val(test_name, "status_out", BUBBLE, status_out);
		check_val(test_name, "new_read", 1'b0, new_read);
		check_val(test_name, "ring_overflow", 1'b0, ring_overflow);
		check_val(test_name, "resp_overflow", 1'b0, resp_overflow);

		test_name = "injection"; // fifo and ring both empty
		tick();
		load_done      = 1'b1;
		new_read_valid = 1'b1;
		new_read_num   = RN_W'($random(seed));
		new_ik_x0      = rand_word();
		new_ik_x1      = rand_word();
		new_ik_x2      = rand_word();
		new_ik_info    = rand_word();
		new_forward_i  = pos_t'($random(seed));
		new_min_intv   = pos_t'($random(seed));
		#1;
		check_val(test_name, "new_read", 1'b1, new_read);
		exp_q.push_back(expect_entry(F_INIT, '0, new_read_num, new_ik_x0, new_ik_x1,
			new_ik_x2, new_ik_info, new_forward_i + 7'd1, new_min_intv, new_forward_i,
			'0, 1'b0));
		name_q.push_back(test_name);
		drain();

		test_name = "query request";
		need = 0;
		for (int i = 0; i < 16; i++) begin
			tick();
			case ($random(seed) & 3)
				0:       st = F_INIT;
				1:       st = F_RUN;
				2:       st = F_BREAK;
				default: st = BUBBLE;
			endcase
			present_context(st);
			if (st == F_INIT || st == F_RUN)
				need++;
		end
		for (int i = 0; i < need; i++) begin
			tick();
			send_response(1'b1);
		end
		drain();

		test_name = "pairing";
		sent = 0;
		for (int i = 0; i < 12; i++) begin
			tick();
			present_context(F_RUN);
			if ($random(seed) & 1) begin // responses trickle in alongside
				send_response(1'b1);
				sent++;
			end
		end
		while (sent < 12) begin
			tick();
			send_response(1'b1);
			sent++;
		end
		drain();

		test_name = "break bypass";
		tick();
		present_context(F_BREAK);
		drain();
		tick();
		send_response(1'b1); // pending response must wait for the run context
		tick();
		present_context(F_BREAK);
		tick();
		present_context(F_RUN);
		drain();

		test_name = "stall";
		for (int i = 0; i < 4; i++) begin
			tick();
			present_context(F_RUN);
		end
		repeat (6) tick();
		send_response(1'b1);
		tick();
		send_response(1'b1);
		tick();
		stall = 1'b1;
		send_response(1'b1); // fifo writes go on
		hold_st  = status_out;
		hold_rn  = read_num_out;
		hold_occ = occ_out[63:0];
		for (int i = 0; i < 5; i++) begin
			tick();
			if (i == 0)
				send_response(1'b1);
			check_val(test_name, "held status_out", hold_st, status_out);
			check_val(test_name, "held read_num_out", hold_rn, read_num_out);
			check_val(test_name, "held occ_out", hold_occ, occ_out[63:0]);
		end
		tick();
		stall = 1'b0;
		drain();

		test_name = "overflow";
		for (int i = 0; i < MAX_READS; i++) begin
			tick();
			send_response(1'b0);
		end
		tick();
		check_val(test_name, "resp_overflow at full", 1'b0, resp_overflow);
		send_response(1'b0); // one past full
		tick();
		check_val(test_name, "resp_overflow", 1'b1, resp_overflow);
		check_val(test_name, "ring_overflow", 1'b0, ring_overflow);

		repeat (4) tick();
		if (exp_q.size() != 0 || occ_exp_q.size() != 0) begin
			errors++;
			$display("ERROR: %0d contexts and %0d responses never left the queue",
				exp_q.size(), occ_exp_q.size());
		end
		assert_errs = dut.u_chk.assert_fails;
		$display("errors: %0d from checks, %0d from assertions", errors, assert_errs);
		if (errors == 0 && assert_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* files.f */
logic/seed_queue_pkg.sv
logic/query_delay_line.sv
logic/context_ring.sv
logic/response_fifo.sv
logic/dispatch_ctrl.sv
logic/seed_queue_top.sv
tests/clock_gen.sv
tests/seed_queue_chk.sv
tests/seed_queue_tb.sv

/* Bender.yml */
package:
  name: seed_queue

sources:
  - logic/seed_queue_pkg.sv
  - logic/query_delay_line.sv
  - logic/context_ring.sv
  - logic/response_fifo.sv
  - logic/dispatch_ctrl.sv
  - logic/seed_queue_top.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/seed_queue_chk.sv
      - tests/seed_queue_tb.sv
